//--- logic/cnn_layer_pkg.sv
package cnn_layer_pkg;

    // ----------------------------------------
    // layer types and field widths
    // ----------------------------------------
    typedef enum logic [1:0] {
        LT_PW  = 2'd0, // pointwise 1x1
        LT_DW  = 2'd1, // depthwise 3x3
        LT_STD = 2'd2, // standard 3x3
        LT_LIN = 2'd3  // linear, treated as 1x1
    } layer_type_e;

    typedef logic [7:0]  dim_t;      // height or width
    typedef logic [10:0] chan_t;     // channel count
    typedef logic [1:0]  pad_t;
    typedef logic [1:0]  stride_t;
    typedef logic [1:0]  ksize_t;
    typedef logic [6:0]  tile_idx_t; // per-axis tile index or count
    typedef logic [13:0] tile_cnt_t; // d_tiles * k_tiles
    typedef logic [31:0] wb_data_t;

    // channel tile sizes
    localparam int unsigned TILE_PW  = 32; // pointwise and linear
    localparam int unsigned TILE_STD = 10; // depthwise and standard

    // ----------------------------------------
    // register map, word addresses
    // ----------------------------------------
    localparam logic [2:0] REG_SHAPE  = 3'd0;
    localparam logic [2:0] REG_CHAN   = 3'd1;
    localparam logic [2:0] REG_CTRL   = 3'd2;
    localparam logic [2:0] REG_RESULT = 3'd3; // read only

    // sequencer states
    typedef enum logic [1:0] {
        S_IDLE,
        S_DECODE,
        S_RUN,
        S_DONE
    } seq_state_e;

endpackage

//--- logic/layer_desc_if.sv
`timescale 1ns/1ns

// raw descriptor fields, static while a layer runs
interface layer_desc_if;
    cnn_layer_pkg::layer_type_e layer_type;
    cnn_layer_pkg::dim_t        in_r;
    cnn_layer_pkg::dim_t        in_c;
    cnn_layer_pkg::chan_t       in_d;
    cnn_layer_pkg::chan_t       out_k;
    cnn_layer_pkg::stride_t     stride;
    cnn_layer_pkg::pad_t        pad_t;
    cnn_layer_pkg::pad_t        pad_b;
    cnn_layer_pkg::pad_t        pad_l;
    cnn_layer_pkg::pad_t        pad_r;

    modport src (
        output layer_type, in_r, in_c, in_d, out_k,
        output stride, pad_t, pad_b, pad_l, pad_r
    );

    modport dst (
        input layer_type, in_r, in_c, in_d, out_k,
        input stride, pad_t, pad_b, pad_l, pad_r
    );
endinterface

//--- logic/desc_regfile.sv
`timescale 1ns/1ns

module desc_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [2:0]              wb_adr_i,
    input  cnn_layer_pkg::wb_data_t wb_dat_i,
    output cnn_layer_pkg::wb_data_t wb_dat_o,
    output logic                    wb_ack_o,
    layer_desc_if.src               desc,
    input  logic                    busy_i,
    input  logic                    done_i,
    input  cnn_layer_pkg::dim_t     out_r_i,
    input  cnn_layer_pkg::dim_t     out_c_i,
    input  cnn_layer_pkg::tile_cnt_t tile_n_i,
    output logic                    start_o
);

    logic                    wb_req;
    logic                    wr_en;
    cnn_layer_pkg::wb_data_t rd_data;

    // new request only while no ack is out
    assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_en  = wb_req && wb_we_i;

    assign start_o = wr_en && (wb_adr_i == cnn_layer_pkg::REG_CTRL) && wb_dat_i[0]
                     && !busy_i; // dropped while a layer runs

    // ----------------------------------------
    // descriptor storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en && wb_adr_i == cnn_layer_pkg::REG_SHAPE) begin
            desc.in_r       <= wb_dat_i[7:0];
            desc.in_c       <= wb_dat_i[15:8];
            desc.layer_type <= cnn_layer_pkg::layer_type_e'(wb_dat_i[17:16]);
            desc.stride     <= wb_dat_i[19:18];
            desc.pad_t      <= wb_dat_i[21:20];
            desc.pad_b      <= wb_dat_i[23:22];
            desc.pad_l      <= wb_dat_i[25:24];
            desc.pad_r      <= wb_dat_i[27:26];
        end
        if (wr_en && wb_adr_i == cnn_layer_pkg::REG_CHAN) begin
            desc.in_d  <= wb_dat_i[10:0];
            desc.out_k <= wb_dat_i[26:16];
        end
    end

    // read mux
    always_comb begin
        unique case (wb_adr_i)
            cnn_layer_pkg::REG_SHAPE:
                rd_data = {4'd0, desc.pad_r, desc.pad_l, desc.pad_b, desc.pad_t,
                           desc.stride, desc.layer_type, desc.in_c, desc.in_r};
            cnn_layer_pkg::REG_CHAN:
                rd_data = {5'd0, desc.out_k, 5'd0, desc.in_d};
            cnn_layer_pkg::REG_CTRL:
                rd_data = {30'd0, done_i, busy_i};
            cnn_layer_pkg::REG_RESULT:
                rd_data = {2'd0, tile_n_i, out_c_i, out_r_i};
            default:
                rd_data = '0; // unmapped
        endcase
    end

    // ----------------------------------------
    // single cycle ack
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= wb_req;
            if (wb_req) begin
                wb_dat_o <= rd_data;
            end
        end
    end

    // an accepted start makes the sequencer busy on the next edge
    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start_o |=> busy_i);

endmodule

//--- logic/tile_count_calc.sv
`timescale 1ns/1ns

module tile_count_calc (
    input  cnn_layer_pkg::layer_type_e layer_type_i,
    input  cnn_layer_pkg::chan_t       in_d_i,
    input  cnn_layer_pkg::chan_t       out_k_i,
    output cnn_layer_pkg::tile_idx_t   d_tiles_o,
    output cnn_layer_pkg::tile_idx_t   k_tiles_o,
    output cnn_layer_pkg::tile_cnt_t   tile_n_o
);

    logic        small_tile;
    logic [11:0] d_ceil; // spare bit for the rounding add
    logic [11:0] k_ceil;

    assign small_tile = (layer_type_i == cnn_layer_pkg::LT_DW) ||
                        (layer_type_i == cnn_layer_pkg::LT_STD);

    // ceiling division by the type's tile size
    always_comb begin
        if (small_tile) begin
            d_ceil = ({1'b0, in_d_i} + 12'(cnn_layer_pkg::TILE_STD - 1))
                     / 12'(cnn_layer_pkg::TILE_STD);
            k_ceil = ({1'b0, out_k_i} + 12'(cnn_layer_pkg::TILE_STD - 1))
                     / 12'(cnn_layer_pkg::TILE_STD);
        end else begin
            d_ceil = ({1'b0, in_d_i} + 12'(cnn_layer_pkg::TILE_PW - 1))
                     / 12'(cnn_layer_pkg::TILE_PW);
            k_ceil = ({1'b0, out_k_i} + 12'(cnn_layer_pkg::TILE_PW - 1))
                     / 12'(cnn_layer_pkg::TILE_PW);
        end
    end

    // counts above 127 per axis wrap
    assign d_tiles_o = cnn_layer_pkg::tile_idx_t'(d_ceil);

    // depthwise keeps each channel in its own group, one k tile
    assign k_tiles_o = (layer_type_i == cnn_layer_pkg::LT_DW)
                       ? cnn_layer_pkg::tile_idx_t'(out_k_i != '0)
                       : cnn_layer_pkg::tile_idx_t'(k_ceil);

    assign tile_n_o = d_tiles_o * k_tiles_o; // zero if either axis is empty

endmodule

//--- logic/layer_decoder.sv
`timescale 1ns/1ns

module layer_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      decode_en_i,
    layer_desc_if.dst                 desc,
    output cnn_layer_pkg::dim_t       out_r_o,
    output cnn_layer_pkg::dim_t       out_c_o,
    output cnn_layer_pkg::tile_idx_t  d_tiles_o,
    output cnn_layer_pkg::tile_idx_t  k_tiles_o,
    output cnn_layer_pkg::tile_cnt_t  tile_n_o
);

    cnn_layer_pkg::ksize_t    ksize;
    cnn_layer_pkg::stride_t   stride_eff;
    logic [8:0]               padded_r; // in + two pads can pass 255
    logic [8:0]               padded_c;
    cnn_layer_pkg::dim_t      out_r;
    cnn_layer_pkg::dim_t      out_c;
    cnn_layer_pkg::tile_idx_t d_tiles;
    cnn_layer_pkg::tile_idx_t k_tiles;
    cnn_layer_pkg::tile_cnt_t tile_n;

    // floor((padded - k) / s) + 1, zero when the kernel does not fit
    function automatic cnn_layer_pkg::dim_t out_dim(
        input logic [8:0]             padded,
        input cnn_layer_pkg::ksize_t  k,
        input cnn_layer_pkg::stride_t s
    );
        logic [8:0] full;
        if (padded < 9'(k)) begin
            full = '0;
        end else begin
            full = (padded - 9'(k)) / 9'(s) + 9'd1;
        end
        return cnn_layer_pkg::dim_t'(full);
    endfunction

    // ----------------------------------------
    // geometry
    // ----------------------------------------
    assign ksize = (desc.layer_type == cnn_layer_pkg::LT_PW ||
                    desc.layer_type == cnn_layer_pkg::LT_LIN) ? 2'd1 : 2'd3;

    assign stride_eff = (desc.stride == 2'd0) ? 2'd1 : desc.stride; // 0 means 1

    assign padded_r = {1'b0, desc.in_r} + 9'(desc.pad_t) + 9'(desc.pad_b);
    assign padded_c = {1'b0, desc.in_c} + 9'(desc.pad_l) + 9'(desc.pad_r);

    assign out_r = out_dim(padded_r, ksize, stride_eff);
    assign out_c = out_dim(padded_c, ksize, stride_eff);

    tile_count_calc i_tile_count_calc (
        .layer_type_i (desc.layer_type),
        .in_d_i       (desc.in_d),
        .out_k_i      (desc.out_k),
        .d_tiles_o    (d_tiles),
        .k_tiles_o    (k_tiles),
        .tile_n_o     (tile_n)
    );

    // latched once per layer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_r_o   <= '0;
            out_c_o   <= '0;
            d_tiles_o <= '0;
            k_tiles_o <= '0;
            tile_n_o  <= '0;
        end else if (decode_en_i) begin
            out_r_o   <= out_r;
            out_c_o   <= out_c;
            d_tiles_o <= d_tiles;
            k_tiles_o <= k_tiles;
            tile_n_o  <= tile_n;
        end
    end

    // a layer only decodes a fully written descriptor
    a_desc_known: assert property (@(posedge clk) disable iff (!rst_n)
        decode_en_i |-> !$isunknown({desc.layer_type, desc.in_r, desc.in_c, desc.in_d,
                                     desc.out_k, desc.stride, desc.pad_t, desc.pad_b,
                                     desc.pad_l, desc.pad_r}));

endmodule

//--- logic/layer_seq_fsm.sv
`timescale 1ns/1ns

module layer_seq_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    input  logic last_tile_i,  // final pair transferring
    input  logic no_tiles_i,   // decoded tile_n is zero
    output logic decode_en_o,
    output logic issue_en_o,
    output logic counter_clear_o,
    output logic busy_o,
    output logic done_o,
    output logic irq_o
);

    cnn_layer_pkg::seq_state_e state_q;
    cnn_layer_pkg::seq_state_e state_d;
    logic                      done_q;

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            cnn_layer_pkg::S_IDLE: begin
                if (start_i) begin
                    state_d = cnn_layer_pkg::S_DECODE;
                end
            end
            cnn_layer_pkg::S_DECODE: begin
                state_d = cnn_layer_pkg::S_RUN;
            end
            cnn_layer_pkg::S_RUN: begin
                // an empty layer leaves at once without issuing
                if (no_tiles_i || last_tile_i) begin
                    state_d = cnn_layer_pkg::S_DONE;
                end
            end
            cnn_layer_pkg::S_DONE: begin
                state_d = start_i ? cnn_layer_pkg::S_DECODE : cnn_layer_pkg::S_IDLE;
            end
            default: state_d = cnn_layer_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cnn_layer_pkg::S_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_d == cnn_layer_pkg::S_DECODE) begin
                done_q <= 1'b0;            // new layer clears done
            end else if (state_d == cnn_layer_pkg::S_DONE) begin
                done_q <= 1'b1;            // sticky until next start
            end
        end
    end

    assign decode_en_o     = (state_q == cnn_layer_pkg::S_DECODE);
    assign counter_clear_o = (state_q == cnn_layer_pkg::S_DECODE);
    assign issue_en_o      = (state_q == cnn_layer_pkg::S_RUN) && !no_tiles_i;
    assign busy_o          = (state_q == cnn_layer_pkg::S_DECODE) ||
                             (state_q == cnn_layer_pkg::S_RUN);
    assign done_o          = done_q;
    assign irq_o           = done_q;

endmodule

//--- logic/tile_counter.sv
`timescale 1ns/1ns

module tile_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear_i,
    input  logic                     issue_en_i,
    input  cnn_layer_pkg::tile_idx_t d_tiles_i,
    input  cnn_layer_pkg::tile_idx_t k_tiles_i,
    input  logic                     tile_ready_i,
    output logic                     tile_valid_o,
    output cnn_layer_pkg::tile_idx_t tile_d_idx_o,
    output cnn_layer_pkg::tile_idx_t tile_k_idx_o,
    output logic                     last_tile_o
);

    logic fire;
    logic k_last;
    logic d_last;

    assign tile_valid_o = issue_en_i;
    assign fire         = issue_en_i && tile_ready_i;
    assign k_last       = (tile_k_idx_o == k_tiles_i - 7'd1);
    assign d_last       = (tile_d_idx_o == d_tiles_i - 7'd1);
    assign last_tile_o  = fire && k_last && d_last;

    // k fastest, carry into d
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_d_idx_o <= '0;
            tile_k_idx_o <= '0;
        end else if (clear_i) begin
            tile_d_idx_o <= '0;
            tile_k_idx_o <= '0;
        end else if (fire) begin
            if (k_last) begin
                tile_k_idx_o <= '0;
                tile_d_idx_o <= d_last ? '0 : tile_d_idx_o + 7'd1;
            end else begin
                tile_k_idx_o <= tile_k_idx_o + 7'd1;
            end
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        tile_valid_o && !tile_ready_i |=> $stable(tile_d_idx_o) && $stable(tile_k_idx_o));

endmodule

//--- logic/accel_ctrl_top.sv
`timescale 1ns/1ns

module accel_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [2:0]               wb_adr_i,
    input  cnn_layer_pkg::wb_data_t  wb_dat_i,
    output cnn_layer_pkg::wb_data_t  wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     tile_valid_o,
    input  logic                     tile_ready_i,
    output cnn_layer_pkg::tile_idx_t tile_d_idx_o,
    output cnn_layer_pkg::tile_idx_t tile_k_idx_o,
    output logic                     irq_o
);

    // ----------------------------------------
    // internal wires
    // ----------------------------------------
    logic                     start;
    logic                     busy;
    logic                     done;
    logic                     decode_en;
    logic                     issue_en;
    logic                     counter_clear;
    logic                     last_tile;
    logic                     no_tiles;
    cnn_layer_pkg::dim_t      out_r;
    cnn_layer_pkg::dim_t      out_c;
    cnn_layer_pkg::tile_idx_t d_tiles;
    cnn_layer_pkg::tile_idx_t k_tiles;
    cnn_layer_pkg::tile_cnt_t tile_n;

    layer_desc_if desc_bus ();

    assign no_tiles = (tile_n == '0);

    desc_regfile i_desc_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .desc     (desc_bus.src),
        .busy_i   (busy),
        .done_i   (done),
        .out_r_i  (out_r),
        .out_c_i  (out_c),
        .tile_n_i (tile_n),
        .start_o  (start)
    );

    layer_decoder i_layer_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .decode_en_i (decode_en),
        .desc        (desc_bus.dst),
        .out_r_o     (out_r),
        .out_c_o     (out_c),
        .d_tiles_o   (d_tiles),
        .k_tiles_o   (k_tiles),
        .tile_n_o    (tile_n)
    );

    layer_seq_fsm i_layer_seq_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start),
        .last_tile_i     (last_tile),
        .no_tiles_i      (no_tiles),
        .decode_en_o     (decode_en),
        .issue_en_o      (issue_en),
        .counter_clear_o (counter_clear),
        .busy_o          (busy),
        .done_o          (done),
        .irq_o           (irq_o)
    );

    tile_counter i_tile_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_i      (counter_clear),
        .issue_en_i   (issue_en),
        .d_tiles_i    (d_tiles),
        .k_tiles_i    (k_tiles),
        .tile_ready_i (tile_ready_i),
        .tile_valid_o (tile_valid_o),
        .tile_d_idx_o (tile_d_idx_o),
        .tile_k_idx_o (tile_k_idx_o),
        .last_tile_o  (last_tile)
    );

endmodule

//--- bench/accel_ctrl_checker.sv
`timescale 1ns/1ns

module accel_ctrl_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [2:0]  wb_adr_i,
    input  logic [31:0] wb_wdat_i,
    input  logic [31:0] wb_rdat_i,
    input  logic        wb_ack_i,
    input  logic        tile_valid_i,
    input  logic        tile_ready_i,
    input  logic [6:0]  tile_d_idx_i,
    input  logic [6:0]  tile_k_idx_i,
    input  logic        irq_i,
    output int          err_cnt_o
);

    logic [31:0] shape_q;
    logic [31:0] chan_q;
    logic [31:0] result_q;
    logic [31:0] pend_data;
    logic        pend_q;
    logic        pend_we;
    logic        done_m;
    cnn_layer_pkg::seq_state_e phase;
    int          d_tiles;
    int          k_tiles;
    int          tiles_left;
    int          exp_d;
    int          exp_k;

    initial err_cnt_o = 0;

    // expected out_R, out_C and channel tile counts of one descriptor
    function automatic void layer_ref(input logic [31:0] shape, input logic [31:0] chan,
                                      output int out_r, output int out_c,
                                      output int d_t, output int k_t);
        int typ;
        int ks;
        int ts;
        int s;
        int pr;
        int pc;
        typ = shape[17:16];
        ks  = (typ == cnn_layer_pkg::LT_DW || typ == cnn_layer_pkg::LT_STD) ? 3 : 1;
        ts  = (ks == 3) ? cnn_layer_pkg::TILE_STD : cnn_layer_pkg::TILE_PW;
        s   = (shape[19:18] == 2'd0) ? 1 : shape[19:18]; // stride 0 acts as 1
        pr  = shape[7:0] + shape[21:20] + shape[23:22];
        pc  = shape[15:8] + shape[25:24] + shape[27:26];
        out_r = (pr < ks) ? 0 : (pr - ks) / s + 1;
        out_c = (pc < ks) ? 0 : (pc - ks) / s + 1;
        d_t   = (chan[10:0] + ts - 1) / ts;
        k_t   = (typ == cnn_layer_pkg::LT_DW) ? (chan[26:16] != 0)
                                              : (chan[26:16] + ts - 1) / ts;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            err_cnt_o++;
        end
    endtask

    always @(posedge clk) begin
        int   out_r;
        int   out_c;
        logic req;
        logic busy;
        logic start;
        if (!rst_n) begin
            phase = cnn_layer_pkg::S_IDLE;
            {shape_q, chan_q, result_q, pend_data} = '0;
            {pend_q, pend_we, done_m} = '0;
            tiles_left = 0;
            exp_d = 0;
            exp_k = 0;
        end else begin
            // ----------------------------------------
            // bus: ack one cycle after each request
            // ----------------------------------------
            if (pend_q) begin
                if (wb_ack_i !== 1'b1) begin
                    $display("%0t: bus request was not acked one cycle later", $time);
                    err_cnt_o++;
                end else if (!pend_we) begin
                    check_val("wb_dat_o", wb_rdat_i, pend_data);
                end
            end else if (wb_ack_i !== 1'b0) begin
                $display("%0t: ack seen without a pending request", $time);
                err_cnt_o++;
            end

            // tile port and interrupt
            check_val("tile_valid_o", tile_valid_i,
                      phase == cnn_layer_pkg::S_RUN && tiles_left != 0);
            if (tile_valid_i) begin
                check_val("tile_d_idx_o", tile_d_idx_i, exp_d);
                check_val("tile_k_idx_o", tile_k_idx_i, exp_k);
            end
            check_val("irq_o", irq_i, done_m);

            req   = wb_cyc_i && wb_stb_i && !wb_ack_i;
            busy  = (phase == cnn_layer_pkg::S_DECODE || phase == cnn_layer_pkg::S_RUN);
            start = req && wb_we_i && wb_adr_i == cnn_layer_pkg::REG_CTRL &&
                    wb_wdat_i[0] && !busy;
            pend_q  = req;
            pend_we = wb_we_i;
            case (wb_adr_i)
                cnn_layer_pkg::REG_SHAPE:  pend_data = shape_q & 32'h0fff_ffff;
                cnn_layer_pkg::REG_CHAN:   pend_data = chan_q & 32'h07ff_07ff;
                cnn_layer_pkg::REG_CTRL:   pend_data = {30'd0, done_m, busy};
                cnn_layer_pkg::REG_RESULT: pend_data = result_q;
                default:                   pend_data = '0;
            endcase

            // ----------------------------------------
            // sequencer model
            // ----------------------------------------
            case (phase)
                cnn_layer_pkg::S_IDLE: begin
                    if (start) begin
                        phase  = cnn_layer_pkg::S_DECODE;
                        done_m = 1'b0;
                    end
                end
                cnn_layer_pkg::S_DECODE: begin
                    layer_ref(shape_q, chan_q, out_r, out_c, d_tiles, k_tiles);
                    tiles_left = d_tiles * k_tiles;
                    result_q   = {2'b00, 14'(tiles_left), 8'(out_c), 8'(out_r)};
                    exp_d = 0;
                    exp_k = 0;
                    phase = cnn_layer_pkg::S_RUN;
                end
                cnn_layer_pkg::S_RUN: begin
                    if (tiles_left == 0) begin
                        phase  = cnn_layer_pkg::S_DONE; // empty layer
                        done_m = 1'b1;
                    end else if (tile_valid_i && tile_ready_i) begin
                        exp_k = (exp_k == k_tiles - 1) ? 0 : exp_k + 1; // k fastest
                        if (exp_k == 0) begin
                            exp_d++;
                        end
                        tiles_left--;
                        if (tiles_left == 0) begin
                            phase  = cnn_layer_pkg::S_DONE;
                            done_m = 1'b1;
                        end
                    end
                end
                default: begin
                    phase = start ? cnn_layer_pkg::S_DECODE : cnn_layer_pkg::S_IDLE;
                    if (start) begin
                        done_m = 1'b0;
                    end
                end
            endcase

            // descriptor shadow, after decode used the old contents
            if (req && wb_we_i && wb_adr_i == cnn_layer_pkg::REG_SHAPE) begin
                shape_q = wb_wdat_i;
            end
            if (req && wb_we_i && wb_adr_i == cnn_layer_pkg::REG_CHAN) begin
                chan_q = wb_wdat_i;
            end
        end
    end

endmodule

//--- bench/accel_ctrl_tb.sv
`timescale 1ns/1ns

module accel_ctrl_tb;

    localparam int N_LAYERS  = 40;
    localparam int MAX_TILES = 100;                 // 99 channels at tile size 10
    localparam int WAIT_CYC  = MAX_TILES * 4 + 50;  // per layer budget
    localparam int RUN_CYC   = 16 + N_LAYERS * WAIT_CYC;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic        tile_valid;
    logic        tile_ready;
    logic [6:0]  tile_d_idx;
    logic [6:0]  tile_k_idx;
    logic        irq;
    logic [31:0] rng;
    int          proto_errs;
    int          check_errs;

    always #2 clk = ~clk;

    accel_ctrl_top i_accel_ctrl_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_wdat),
        .wb_dat_o     (wb_rdat),
        .wb_ack_o     (wb_ack),
        .tile_valid_o (tile_valid),
        .tile_ready_i (tile_ready),
        .tile_d_idx_o (tile_d_idx),
        .tile_k_idx_o (tile_k_idx),
        .irq_o        (irq)
    );

    accel_ctrl_checker i_accel_ctrl_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_wdat_i    (wb_wdat),
        .wb_rdat_i    (wb_rdat),
        .wb_ack_i     (wb_ack),
        .tile_valid_i (tile_valid),
        .tile_ready_i (tile_ready),
        .tile_d_idx_i (tile_d_idx),
        .tile_k_idx_i (tile_k_idx),
        .irq_i        (irq),
        .err_cnt_o    (check_errs)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one classic cycle, held until the ack shows up
    task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] dat);
        int waited;
        waited = 0;
        @(negedge clk);
        {wb_cyc, wb_stb, wb_we} = {2'b11, we};
        wb_adr  = adr;
        wb_wdat = dat;
        @(negedge clk);
        while (!wb_ack && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            $display("%0t: no ack for access to register %0d", $time, adr);
            proto_errs++;
        end
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    task automatic wait_done(input int layer);
        int n;
        n = 0;
        while (!irq && n < WAIT_CYC) begin
            @(negedge clk);
            rng = xorshift32(rng);
            tile_ready = (rng[1:0] != 2'd0); // stall roughly one cycle in four
            n++;
        end
        if (!irq) begin
            $display("layer %0d: interrupt never arrived", layer);
            proto_errs++;
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        logic [31:0] shape;
        logic [31:0] chan;
        clk = 1'b0;
        rst_n = 1'b0;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_wdat} = '0;
        tile_ready = 1'b0;
        rng = 32'd23066;
        proto_errs = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < N_LAYERS; i++) begin
            rng = xorshift32(rng);
            shape = rng & 32'hfff0_3f3f;    // junk in 31:28 must read back as zero
            shape[17:16] = 2'(i);           // every type
            shape[19:18] = 2'(i / 4);       // strides 0..3
            if (i % 5 == 0) begin
                shape[7:0] = 8'(rng[9:8] % 3); // padded rows below a 3x3 kernel
                shape[23:20] = 4'd0;
            end
            rng = xorshift32(rng);
            chan = (rng & 32'hf800_f800) |
                   {5'd0, 11'(1 + rng[23:16] % 99), 5'd0, 11'(1 + rng[7:0] % 99)};
            if (i % 7 == 3) begin
                if (i % 2 == 1) chan[10:0] = '0;
                else chan[26:16] = '0;
            end
            bus_access(1'b1, cnn_layer_pkg::REG_SHAPE, shape);
            bus_access(1'b1, cnn_layer_pkg::REG_CHAN, chan);
            bus_access(1'b0, cnn_layer_pkg::REG_SHAPE, '0);
            bus_access(1'b0, cnn_layer_pkg::REG_CHAN, '0);
            bus_access(1'b1, 3'(4 + i % 4), rng);   // unmapped
            bus_access(1'b0, 3'(4 + i % 4), '0);
            bus_access(1'b1, cnn_layer_pkg::REG_CTRL, 32'd1);
            if (i % 2 == 1) begin
                bus_access(1'b1, cnn_layer_pkg::REG_CTRL, 32'd1); // busy, dropped
                bus_access(1'b0, cnn_layer_pkg::REG_CTRL, '0);
            end
            wait_done(i);
            bus_access(1'b0, cnn_layer_pkg::REG_CTRL, '0);
            bus_access(1'b0, cnn_layer_pkg::REG_RESULT, '0);
        end
        repeat (4) @(negedge clk);
        $display("errors: %0d compare, %0d bus or interrupt", check_errs, proto_errs);
        if (check_errs == 0 && proto_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(RUN_CYC * 4);
        $display("timeout: run did not finish within %0d cycles", RUN_CYC);
        $display("errors: %0d compare, %0d bus or interrupt", check_errs, proto_errs);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- filelist.f
logic/cnn_layer_pkg.sv
logic/layer_desc_if.sv
logic/desc_regfile.sv
logic/tile_count_calc.sv
logic/layer_decoder.sv
logic/layer_seq_fsm.sv
logic/tile_counter.sv
logic/accel_ctrl_top.sv
bench/accel_ctrl_checker.sv
bench/accel_ctrl_tb.sv
